//--- Bender.yml
package:
  name: exec_unit

sources:
  - hw/rv_isa_pkg.sv
  - hw/exec_pkg.sv
  - hw/instr_decoder.sv
  - hw/op_queue.sv
  - hw/int_alu.sv
  - hw/branch_unit.sv
  - hw/exec_stage.sv
  - hw/exec_unit_top.sv
  - target: test
    files:
      - testbench/tb_exec_unit.sv

//--- flist.f
hw/rv_isa_pkg.sv
hw/exec_pkg.sv
hw/instr_decoder.sv
hw/op_queue.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/exec_stage.sv
hw/exec_unit_top.sv
testbench/tb_exec_unit.sv

//--- hw/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  exec_pkg::op_kind_e              kind,
    input  rv_isa_pkg::branch_funct3_e      br_cond,
    input  logic [rv_isa_pkg::xlen-1:0]     rs1,
    input  logic [rv_isa_pkg::xlen-1:0]     rs2,
    input  logic [rv_isa_pkg::xlen-1:0]     imm,
    input  logic [rv_isa_pkg::pc_width-1:0] pc,
    output logic                            taken,
    output logic [rv_isa_pkg::pc_width-1:0] target,
    output logic [rv_isa_pkg::xlen-1:0]     link
);

    logic                            cond;
    logic [rv_isa_pkg::xlen-1:0]     reg_sum;
    logic [rv_isa_pkg::pc_width-1:0] next_pc;

    assign next_pc = pc + rv_isa_pkg::pc_width'(rv_isa_pkg::pc_step);
    assign reg_sum = rs1 + imm;
    assign link    = {{(rv_isa_pkg::xlen - rv_isa_pkg::pc_width){1'b0}}, next_pc};

    always_comb begin
        case (br_cond)
            rv_isa_pkg::beq:  cond = (rs1 == rs2);
            rv_isa_pkg::bne:  cond = (rs1 != rs2);
            rv_isa_pkg::blt:  cond = ($signed(rs1) < $signed(rs2));
            rv_isa_pkg::bge:  cond = ($signed(rs1) >= $signed(rs2));
            rv_isa_pkg::bltu: cond = (rs1 < rs2);
            rv_isa_pkg::bgeu: cond = (rs1 >= rs2);
            default:          cond = 1'b0;
        endcase
    end

    always_comb begin
        case (kind)
            exec_pkg::branch:      taken = cond;
            exec_pkg::jump_direct: taken = 1'b1;
            exec_pkg::jump_reg:    taken = 1'b1;
            default:               taken = 1'b0;
        endcase
        if (kind == exec_pkg::jump_reg) begin
            // JALR drops bit 0 of the sum
            target = {reg_sum[rv_isa_pkg::pc_width-1:1], 1'b0};
        end else if (taken) begin
            target = pc + imm[rv_isa_pkg::pc_width-1:0];
        end else begin
            target = next_pc;
        end
    end

endmodule

//--- hw/exec_pkg.sv
package exec_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_zero
    } alu_op_e;

    typedef enum logic [1:0] {
        alu,
        branch,
        jump_direct,
        jump_reg
    } op_kind_e;

    // Raw request as it arrives from upstream
    typedef struct packed {
        logic [6:0]                      opcode;
        logic [2:0]                      func3;
        logic [6:0]                      func7;
        logic [rv_isa_pkg::xlen-1:0]     imm;
        logic [rv_isa_pkg::xlen-1:0]     rs1;
        logic [rv_isa_pkg::xlen-1:0]     rs2;
        logic [rv_isa_pkg::pc_width-1:0] pc;
    } exec_req_t;

    typedef struct packed {
        op_kind_e                        kind;
        alu_op_e                         alu_op;
        rv_isa_pkg::branch_funct3_e      br_cond;
        logic [rv_isa_pkg::xlen-1:0]     op_a;
        logic [rv_isa_pkg::xlen-1:0]     op_b;
        logic [rv_isa_pkg::xlen-1:0]     rs1;
        logic [rv_isa_pkg::xlen-1:0]     rs2;
        logic [rv_isa_pkg::xlen-1:0]     imm;
        logic [rv_isa_pkg::pc_width-1:0] pc;
    } dec_op_t;

    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0]     result;
        logic                            is_branch;
        logic [rv_isa_pkg::pc_width-1:0] branch_target;
    } exec_resp_t;

    // Upstream credits equal the queue slots
    localparam int queue_depth = 4;
    localparam int out_credits = 2;

endpackage

//--- hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 head_valid,
    input  exec_pkg::dec_op_t    head_op,
    output logic                 pop,
    input  logic                 resp_credit,
    output logic                 resp_valid,
    output exec_pkg::exec_resp_t resp
);

    typedef logic [$clog2(exec_pkg::out_credits + 1)-1:0] credit_t;

    credit_t                         credits;
    logic [rv_isa_pkg::xlen-1:0]     alu_result;
    logic [rv_isa_pkg::xlen-1:0]     link;
    logic [rv_isa_pkg::pc_width-1:0] target;
    logic                            taken;
    exec_pkg::exec_resp_t            resp_n;

    int_alu u_alu (
        .alu_op (head_op.alu_op),
        .op_a   (head_op.op_a),
        .op_b   (head_op.op_b),
        .result (alu_result)
    );

    branch_unit u_branch (
        .kind    (head_op.kind),
        .br_cond (head_op.br_cond),
        .rs1     (head_op.rs1),
        .rs2     (head_op.rs2),
        .imm     (head_op.imm),
        .pc      (head_op.pc),
        .taken   (taken),
        .target  (target),
        .link    (link)
    );

    // Credit is taken when the op issues
    assign pop = head_valid && (credits != '0);

    always_comb begin
        resp_n.is_branch     = taken;
        resp_n.branch_target = target;
        case (head_op.kind)
            exec_pkg::alu:         resp_n.result = alu_result;
            exec_pkg::jump_direct: resp_n.result = link;
            exec_pkg::jump_reg:    resp_n.result = link;
            default:               resp_n.result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits    <= credit_t'(exec_pkg::out_credits);
            resp_valid <= 1'b0;
        end else begin
            credits    <= credits + credit_t'(resp_credit) - credit_t'(pop);
            resp_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp <= resp_n;
        end
    end

endmodule

//--- hw/exec_unit_top.sv
`timescale 1ns/1ps

module exec_unit_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  exec_pkg::exec_req_t  req,
    output logic                 req_credit,
    output logic                 resp_valid,
    output exec_pkg::exec_resp_t resp,
    input  logic                 resp_credit
);

    logic              dec_valid;
    exec_pkg::dec_op_t dec_op;
    logic              q_valid;
    exec_pkg::dec_op_t q_op;
    logic              q_pop;

    instr_decoder u_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .dec_valid (dec_valid),
        .dec_op    (dec_op)
    );

    op_queue u_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (dec_valid),
        .push_op    (dec_op),
        .pop        (q_pop),
        .head_valid (q_valid),
        .head_op    (q_op),
        .credit     (req_credit)
    );

    exec_stage u_exec (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (q_valid),
        .head_op     (q_op),
        .pop         (q_pop),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  exec_pkg::exec_req_t req,
    output logic                dec_valid,
    output exec_pkg::dec_op_t   dec_op
);

    exec_pkg::dec_op_t           op_n;
    logic [rv_isa_pkg::xlen-1:0] upper_imm;

    // ALU operation for OP and OP_imm, reg_form checks func7 on every func3
    function automatic exec_pkg::alu_op_e arith_op(input logic [2:0] f3,
                                                   input logic [6:0] f7,
                                                   input logic       reg_form);
        logic base;
        logic alt;
        exec_pkg::alu_op_e plain;
        base = (f7 == rv_isa_pkg::funct7_base);
        alt  = (f7 == rv_isa_pkg::funct7_alt);
        case (rv_isa_pkg::funct3_e'(f3))
            rv_isa_pkg::sll:    plain = exec_pkg::alu_sll;
            rv_isa_pkg::slt:    plain = exec_pkg::alu_slt;
            rv_isa_pkg::sltu:   plain = exec_pkg::alu_sltu;
            rv_isa_pkg::xor_op: plain = exec_pkg::alu_xor;
            rv_isa_pkg::or_op:  plain = exec_pkg::alu_or;
            rv_isa_pkg::and_op: plain = exec_pkg::alu_and;
            default:            plain = exec_pkg::alu_add;
        endcase
        if (f3 == rv_isa_pkg::srl_sra) begin
            // Shift direction always needs func7, immediate form too
            if (base) begin
                return exec_pkg::alu_srl;
            end else if (alt) begin
                return exec_pkg::alu_sra;
            end
            return exec_pkg::alu_pass_zero;
        end
        if (!reg_form || base) begin
            return plain;
        end
        if (alt && f3 == rv_isa_pkg::add_sub) begin
            return exec_pkg::alu_sub;
        end
        return exec_pkg::alu_pass_zero;
    endfunction

    assign upper_imm = {{32{req.imm[19]}}, req.imm[19:0], 12'b0};

    always_comb begin
        op_n         = '0;
        op_n.kind    = exec_pkg::alu;
        op_n.alu_op  = exec_pkg::alu_pass_zero;
        op_n.br_cond = rv_isa_pkg::beq;
        op_n.rs1     = req.rs1;
        op_n.rs2     = req.rs2;
        op_n.imm     = req.imm;
        op_n.pc      = req.pc;
        case (req.opcode)
            rv_isa_pkg::op: begin
                op_n.alu_op = arith_op(req.func3, req.func7, 1'b1);
                op_n.op_a   = req.rs1;
                op_n.op_b   = req.rs2;
            end
            rv_isa_pkg::op_imm: begin
                op_n.alu_op = arith_op(req.func3, req.func7, 1'b0);
                op_n.op_a   = req.rs1;
                op_n.op_b   = req.imm;
            end
            rv_isa_pkg::lui: begin
                op_n.alu_op = exec_pkg::alu_add;
                op_n.op_b   = upper_imm;
            end
            rv_isa_pkg::auipc: begin
                op_n.alu_op = exec_pkg::alu_add;
                op_n.op_a   = {{(rv_isa_pkg::xlen - rv_isa_pkg::pc_width){1'b0}}, req.pc};
                op_n.op_b   = upper_imm;
            end
            rv_isa_pkg::branch: begin
                // Reserved branch func3 stays an illegal ALU op
                if (req.func3 != 3'b010 && req.func3 != 3'b011) begin
                    op_n.kind    = exec_pkg::branch;
                    op_n.br_cond = rv_isa_pkg::branch_funct3_e'(req.func3);
                end
            end
            rv_isa_pkg::jal:  op_n.kind = exec_pkg::jump_direct;
            rv_isa_pkg::jalr: op_n.kind = exec_pkg::jump_reg;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec_op <= op_n;
        end
    end

endmodule

//--- hw/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  exec_pkg::alu_op_e           alu_op,
    input  logic [rv_isa_pkg::xlen-1:0] op_a,
    input  logic [rv_isa_pkg::xlen-1:0] op_b,
    output logic [rv_isa_pkg::xlen-1:0] result
);

    logic [rv_isa_pkg::shamt_width-1:0] shamt;
    logic                               lt_signed;
    logic                               lt_unsigned;

    assign shamt       = op_b[rv_isa_pkg::shamt_width-1:0];
    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);

    always_comb begin
        case (alu_op)
            exec_pkg::alu_add: begin
                result = op_a + op_b;
            end
            exec_pkg::alu_sub: begin
                result = op_a - op_b;
            end
            exec_pkg::alu_sll: begin
                result = op_a << shamt;
            end
            exec_pkg::alu_slt: begin
                result = {{(rv_isa_pkg::xlen - 1){1'b0}}, lt_signed};
            end
            exec_pkg::alu_sltu: begin
                result = {{(rv_isa_pkg::xlen - 1){1'b0}}, lt_unsigned};
            end
            exec_pkg::alu_xor: begin
                result = op_a ^ op_b;
            end
            exec_pkg::alu_srl: begin
                result = op_a >> shamt;
            end
            exec_pkg::alu_sra: begin
                // Sign bit fills from the left
                result = $unsigned($signed(op_a) >>> shamt);
            end
            exec_pkg::alu_or: begin
                result = op_a | op_b;
            end
            exec_pkg::alu_and: begin
                result = op_a & op_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- hw/op_queue.sv
`timescale 1ns/1ps

module op_queue (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  exec_pkg::dec_op_t push_op,
    input  logic              pop,
    output logic              head_valid,
    output exec_pkg::dec_op_t head_op,
    output logic              credit
);

    typedef logic [$clog2(exec_pkg::queue_depth)-1:0] ptr_t;
    typedef logic [$clog2(exec_pkg::queue_depth):0]   count_t;

    exec_pkg::dec_op_t mem [exec_pkg::queue_depth];
    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    count_t            count;
    logic              do_pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(exec_pkg::queue_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_op    = mem[rd_ptr];
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves occupancy unchanged
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back upstream per slot freed
            credit <= do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_op;
        end
    end

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen     = 64;
    localparam int pc_width = 32;

    // Base opcodes handled by the execute unit
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        auipc  = 7'b0010111,
        lui    = 7'b0110111
    } opcode_e;

    // func3 for OP and OP_imm
    typedef enum logic [2:0] {
        add_sub = 3'b000,
        sll     = 3'b001,
        slt     = 3'b010,
        sltu    = 3'b011,
        xor_op  = 3'b100,
        srl_sra = 3'b101,
        or_op   = 3'b110,
        and_op  = 3'b111
    } funct3_e;

    // func3 for BRANCH, 3'b010 and 3'b011 are reserved
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    localparam logic [6:0] funct7_base = 7'b0000000;
    // Selects sub and sra
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    localparam int shamt_width = 6;
    localparam int pc_step     = 4;

endpackage

//--- testbench/exec_cases.txt
# opcode func3 func7 imm rs1 rs2 pc | expected result is_branch target
# all fields hex, one test per line
33 0 00 0000000000000000 0000000000000005 0000000000000007 00001000 000000000000000c 0 00001004
33 0 20 0000000000000000 0000000000000000 0000000000000001 00001000 ffffffffffffffff 0 00001004
33 1 00 0000000000000000 0000000000000001 0000000000000043 00001000 0000000000000008 0 00001004
33 2 00 0000000000000000 ffffffffffffffff 0000000000000001 00001000 0000000000000001 0 00001004
33 3 00 0000000000000000 ffffffffffffffff 0000000000000001 00001000 0000000000000000 0 00001004
33 4 00 0000000000000000 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 00001000 f00ff00ff00ff00f 0 00001004
33 5 00 0000000000000000 8000000000000000 0000000000000004 00001000 0800000000000000 0 00001004
33 5 20 0000000000000000 8000000000000000 0000000000000004 00001000 f800000000000000 0 00001004
33 6 00 0000000000000000 00000000000000f0 000000000000000f 00001000 00000000000000ff 0 00001004
33 7 00 0000000000000000 123456789abcdef0 00000000ffffffff 00001000 000000009abcdef0 0 00001004
33 0 01 0000000000000000 0000000000000005 0000000000000007 00001000 0000000000000000 0 00001004
13 0 00 fffffffffffffff0 0000000000000010 0000000000000000 00001000 0000000000000000 0 00001004
13 1 00 0000000000000041 0000000000000003 0000000000000000 00001000 0000000000000006 0 00001004
13 5 20 000000000000043f 8000000000000000 0000000000000000 00001000 ffffffffffffffff 0 00001004
13 2 00 ffffffffffffffff 0000000000000001 0000000000000000 00001000 0000000000000000 0 00001004
13 3 00 ffffffffffffffff 0000000000000001 0000000000000000 00001000 0000000000000001 0 00001004
13 7 00 000000000000000f 00000000000000ff 0000000000000000 00001000 000000000000000f 0 00001004
37 0 00 0000000000012345 0000000000000000 0000000000000000 00001000 0000000012345000 0 00001004
37 0 00 0000000000080000 0000000000000000 0000000000000000 00001000 ffffffff80000000 0 00001004
17 0 00 0000000000000001 0000000000000000 0000000000000000 00001000 0000000000002000 0 00001004
17 0 00 00000000000fffff 0000000000000000 0000000000000000 00002000 0000000000001000 0 00002004
03 0 00 0000000000000000 0000000000000005 0000000000000007 00001000 0000000000000000 0 00001004
63 0 00 fffffffffffffff0 0000000000000005 0000000000000005 00003000 0000000000000000 1 00002ff0
63 0 00 0000000000000100 0000000000000005 0000000000000006 00003000 0000000000000000 0 00003004
63 1 00 0000000000000100 0000000000000005 0000000000000006 00003000 0000000000000000 1 00003100
63 1 00 0000000000000100 0000000000000005 0000000000000005 00003000 0000000000000000 0 00003004
63 4 00 0000000000000100 ffffffffffffffff 0000000000000001 00003000 0000000000000000 1 00003100
63 4 00 0000000000000100 0000000000000001 ffffffffffffffff 00003000 0000000000000000 0 00003004
63 5 00 0000000000000100 0000000000000001 ffffffffffffffff 00003000 0000000000000000 1 00003100
63 5 00 0000000000000100 ffffffffffffffff 0000000000000001 00003000 0000000000000000 0 00003004
63 6 00 0000000000000100 0000000000000001 ffffffffffffffff 00003000 0000000000000000 1 00003100
63 6 00 0000000000000100 ffffffffffffffff 0000000000000001 00003000 0000000000000000 0 00003004
63 7 00 0000000000000100 ffffffffffffffff 0000000000000001 00003000 0000000000000000 1 00003100
63 7 00 0000000000000100 0000000000000001 ffffffffffffffff 00003000 0000000000000000 0 00003004
63 2 00 0000000000000100 0000000000000005 0000000000000005 00003000 0000000000000000 0 00003004
6f 0 00 0000000000000800 0000000000000000 0000000000000000 00004000 0000000000004004 1 00004800
67 0 00 0000000000000010 0000000000005001 0000000000000000 00006000 0000000000006004 1 00005010

//--- testbench/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;

    localparam int wait_limit   = 200;
    localparam int stall_cycles = 20;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 req_valid;
    exec_pkg::exec_req_t  req;
    logic                 req_credit;
    logic                 resp_valid;
    exec_pkg::exec_resp_t resp;
    logic                 resp_credit;

    exec_pkg::exec_req_t  reqs [$];
    exec_pkg::exec_resp_t exps [$];
    exec_pkg::exec_resp_t exp_q [$];
    int                   id_q [$];

    integer seed            = 32'h5cba_5be7;
    int     num_cases       = 0;
    int     sent            = 0;
    int     received        = 0;
    int     returned_up     = 0;
    int     up_credits      = exec_pkg::queue_depth;
    int     held            = exec_pkg::out_credits;
    int     pending_credits = 0;
    int     pass_count      = 0;
    int     fail_count      = 0;
    int     errors          = 0;
    logic   hold_credit     = 1'b1;
    logic   timed_out       = 1'b0;

    exec_unit_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

    always #10 clk = ~clk;

    task automatic load_cases();
        int                              fd;
        int                              code;
        string                           line;
        logic [6:0]                      opc;
        logic [2:0]                      f3;
        logic [6:0]                      f7;
        logic [rv_isa_pkg::xlen-1:0]     imm;
        logic [rv_isa_pkg::xlen-1:0]     a;
        logic [rv_isa_pkg::xlen-1:0]     b;
        logic [rv_isa_pkg::pc_width-1:0] pc;
        logic [rv_isa_pkg::xlen-1:0]     res;
        logic                            br;
        logic [rv_isa_pkg::pc_width-1:0] tgt;
        exec_pkg::exec_req_t             r;
        exec_pkg::exec_resp_t            e;
        fd = $fopen("testbench/exec_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the case file");
            errors++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                   opc, f3, f7, imm, a, b, pc, res, br, tgt);
                    if (code == 10) begin
                        r = '{opcode: opc, func3: f3, func7: f7, imm: imm,
                              rs1: a, rs2: b, pc: pc};
                        e = '{result: res, is_branch: br, branch_target: tgt};
                        reqs.push_back(r);
                        exps.push_back(e);
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_case(input int idx);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < wait_limit) begin
            req_valid = 1'b0;
            @(negedge clk);
            waited++;
        end
        if (up_credits == 0) begin
            $display("Timeout at %0t: no upstream credit came back for case %0d", $time, idx);
            timed_out = 1'b1;
        end else begin
            req_valid = 1'b1;
            req       = reqs[idx];
            up_credits--;
            sent++;
            exp_q.push_back(exps[idx]);
            id_q.push_back(idx);
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic send_range(input int first, input int last);
        int i;
        for (i = first; i < last; i++) begin
            if (!timed_out) begin
                send_case(i);
            end
        end
    endtask

    task automatic wait_responses(input int target);
        int waited;
        waited = 0;
        while (received < target && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (received < target) begin
            $display("Timeout at %0t: only %0d of %0d responses arrived",
                     $time, received, target);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_response();
        exec_pkg::exec_resp_t want;
        int                   id;
        logic                 ok;
        assert (exp_q.size() != 0) else begin
            $display("Response at time %0t with no request outstanding", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            id   = id_q.pop_front();
            ok   = 1'b1;
            assert (resp.result == want.result) else begin
                $display("Fail at %0t: resp.result got %h expected %h",
                         $time, resp.result, want.result);
                ok = 1'b0;
            end
            assert (resp.is_branch == want.is_branch) else begin
                $display("Fail at %0t: resp.is_branch got %b expected %b",
                         $time, resp.is_branch, want.is_branch);
                ok = 1'b0;
            end
            assert (resp.branch_target == want.branch_target) else begin
                $display("Fail at %0t: resp.branch_target got %h expected %h",
                         $time, resp.branch_target, want.branch_target);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count++;
                $display("case %0d: pass", id);
            end else begin
                fail_count++;
                $display("case %0d: fail", id);
            end
        end
    endtask

    // Outputs sampled on the rising edge, before the DUT updates them
    always @(posedge clk) begin
        if (arst_n === 1'b1) begin
            if (sent == 0) begin
                assert (!resp_valid && !req_credit) else begin
                    $display("Output active at time %0t before any request was sent", $time);
                    errors++;
                end
            end
            if (req_credit) begin
                up_credits++;
                returned_up++;
            end
            if (resp_valid) begin
                assert (held > 0) else begin
                    $display("Response at time %0t without a downstream credit", $time);
                    errors++;
                end
                held--;
                received++;
                pending_credits++;
                check_response();
            end
            if (resp_credit) begin
                held++;
            end
        end
    end

    // One credit back per response, 0 to 3 cycles late
    initial begin : credit_return
        int gap;
        forever begin
            @(negedge clk);
            resp_credit = 1'b0;
            if (!hold_credit && pending_credits > 0) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
                resp_credit = 1'b1;
                pending_credits--;
            end
        end
    end

    initial begin : main_flow
        int stall_base;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        resp_credit = 1'b0;
        load_cases();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);
        if (num_cases < exec_pkg::out_credits + exec_pkg::queue_depth) begin
            $display("Case file holds only %0d usable lines", num_cases);
            errors++;
        end else begin
            // Spend the reset credits while returns are held back
            send_range(0, exec_pkg::out_credits);
            if (!timed_out) begin
                wait_responses(exec_pkg::out_credits);
            end
            // Queue fills up and nothing may leave
            send_range(exec_pkg::out_credits, exec_pkg::out_credits + exec_pkg::queue_depth);
            stall_base = received;
            repeat (stall_cycles) @(negedge clk);
            assert (received == stall_base) else begin
                $display("Response appeared while downstream credit was withheld");
                errors++;
            end
            assert (up_credits == 0) else begin
                $display("Sender still held %0d upstream credits with a full queue", up_credits);
                errors++;
            end
            hold_credit = 1'b0;
            send_range(exec_pkg::out_credits + exec_pkg::queue_depth, num_cases);
            if (!timed_out) begin
                wait_responses(num_cases);
            end
            repeat (8) @(negedge clk);
            assert (returned_up == received) else begin
                $display("Upstream credits returned %0d differ from responses %0d",
                         returned_up, received);
                errors++;
            end
        end
        $display("passed %0d failed %0d", pass_count, fail_count);
        if (!timed_out && errors == 0 && fail_count == 0 && pass_count == num_cases) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
